//--- rtl/calc_pkg.sv
// calculator arithmetic definitions
// data width, operator encoding and control FSM states

package calc_pkg;

   // unsigned arithmetic wraps modulo 2**DATA_W
   localparam int DATA_W = 10;

   // digit entry stops once the argument reaches this value
   localparam int ARG_LIMIT = 100;

   typedef enum logic [1:0]
   {
      OP_PLUS     = 2'd0,
      OP_MINUS    = 2'd1,
      OP_MULTIPLY = 2'd2,
      OP_DIVIDE   = 2'd3
   } calc_op_t;

   typedef enum logic [3:0]
   {
      CLEAR       = 4'd0, // zero argument, result and display
      READ        = 4'd1, // idle, waiting for a key
      DIGIT       = 4'd2,
      OPERATOR    = 4'd3,
      CALCULATE   = 4'd4,
      DIVIDING    = 4'd5, // waiting on the divider
      SHOW_ARG    = 4'd6,
      SHOW_RESULT = 4'd7
   } calc_state_t;

endpackage

//--- rtl/panel_pkg.sv
// front panel definitions
// keypad codes, scan pacing and display geometry

package panel_pkg;

   localparam int KEY_W    = 4;
   localparam int KEYPAD_N = 4; // rows and columns

   // key code is row * KEYPAD_N + column
   localparam logic [KEY_W-1:0] KEY_PLUS     = 4'hA;
   localparam logic [KEY_W-1:0] KEY_MINUS    = 4'hB;
   localparam logic [KEY_W-1:0] KEY_MULT     = 4'hC;
   localparam logic [KEY_W-1:0] KEY_DIV      = 4'hD;
   localparam logic [KEY_W-1:0] KEY_CLEAR_LO = 4'hE; // E and F both clear

   // clocks per scan tick
   localparam int SCAN_DIV = 8;

   // seven segment display, one digit lit at a time
   localparam int DIGITS = 4;
   localparam int SEG_W  = 7; // g down to a, active high

endpackage

//--- rtl/scan_timer.sv
// scan timer
// one-cycle tick every SCAN_DIV clocks for keypad and display stepping
`timescale 1ns/100ps

module scan_timer (
   input  logic clk,
   input  logic rst_n,
   output logic scan_tick
);
   import panel_pkg::*;

   logic [$clog2(SCAN_DIV)-1:0] cnt;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         cnt       <= '0;
         scan_tick <= 1'b0;
      end
      else
      begin
         if (cnt == ($clog2(SCAN_DIV))'(SCAN_DIV - 1))
         begin
            cnt       <= '0;
            scan_tick <= 1'b1; // wrap
         end
         else
         begin
            cnt       <= cnt + 1'b1;
            scan_tick <= 1'b0;
         end
      end
   end

endmodule

//--- rtl/keypad_scanner.sv
// keypad scanner
// walks the columns, encodes a pressed key, one strobe per press
`timescale 1ns/100ps

module keypad_scanner (
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        scan_tick,
   input  logic [panel_pkg::KEYPAD_N-1:0] key_row,
   output logic [panel_pkg::KEYPAD_N-1:0] key_col,
   output logic                        key_valid,
   output logic [panel_pkg::KEY_W-1:0] key_code
);
   import panel_pkg::*;

   logic [$clog2(KEYPAD_N)-1:0] col_idx;
   logic [$clog2(KEYPAD_N)-1:0] row_idx;
   logic                        row_hit;
   logic                        sweep_end;
   logic                        seen_cur;  // key seen so far this sweep
   logic                        seen_last; // key seen in previous sweep
   logic                        seen_now;
   logic [KEY_W-1:0]            hit_code;
   logic [KEY_W-1:0]            code_now;

   // lowest pressed row in the driven column
   always_comb
   begin
      row_hit = 1'b0;
      row_idx = '0;
      for (int r = KEYPAD_N - 1; r >= 0; r--)
      begin
         if (key_row[r])
         begin
            row_hit = 1'b1;
            row_idx = ($clog2(KEYPAD_N))'(r);
         end
      end
   end

   assign key_col   = KEYPAD_N'(1) << col_idx;
   assign sweep_end = scan_tick && (col_idx == ($clog2(KEYPAD_N))'(KEYPAD_N - 1));
   assign seen_now  = seen_cur | row_hit;
   assign code_now  = row_hit ? {row_idx, col_idx} : hit_code; // row*4 + col

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         col_idx   <= '0;
         seen_cur  <= 1'b0;
         seen_last <= 1'b0;
         key_valid <= 1'b0;
      end
      else
      begin
         key_valid <= 1'b0;
         if (scan_tick)
         begin
            col_idx <= col_idx + 1'b1; // sample first, then advance
            if (sweep_end)
            begin
               key_valid <= seen_now && !seen_last; // rising edge only
               seen_last <= seen_now;
               seen_cur  <= 1'b0;
            end
            else
            begin
               seen_cur <= seen_now;
            end
         end
      end
   end

   // key code registers
   always_ff @(posedge clk)
   begin
      if (scan_tick && row_hit)
         hit_code <= {row_idx, col_idx};
      if (sweep_end && seen_now && !seen_last)
         key_code <= code_now; // held until the next press
   end

endmodule

//--- rtl/calc_control.sv
// calculator control FSM
// builds the decimal argument and applies the pending operator to the result
// divide is handed to the sequential divider
`timescale 1ns/100ps

module calc_control (
   input  logic                         clk,
   input  logic                         rst_n,
   input  logic                         key_valid,
   input  logic [panel_pkg::KEY_W-1:0]  key_code,
   input  logic                         div_done,
   input  logic [calc_pkg::DATA_W-1:0]  div_quot,
   output logic                         div_start,
   output logic [calc_pkg::DATA_W-1:0]  div_num,
   output logic [calc_pkg::DATA_W-1:0]  div_den,
   output logic [calc_pkg::DATA_W-1:0]  show_value
);
   import calc_pkg::*;
   import panel_pkg::*;

   calc_state_t       state;
   calc_op_t          op;      // pending operator
   calc_op_t          op_next; // operator just pressed
   logic [DATA_W-1:0] arg;
   logic [DATA_W-1:0] result;

   // key_code stays stable until the next press, which takes whole sweeps
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state      <= CLEAR;
         op         <= OP_PLUS;
         op_next    <= OP_PLUS;
         arg        <= '0;
         result     <= '0;
         show_value <= '0;
         div_start  <= 1'b0;
      end
      else
      begin
         div_start <= 1'b0;
         case (state)
            CLEAR:
            begin
               arg        <= '0;
               result     <= '0;
               show_value <= '0;
               op         <= OP_PLUS;
               state      <= READ;
            end
            READ:
            begin
               if (key_valid)
               begin
                  if (key_code < KEY_PLUS)
                     state <= DIGIT;
                  else if (key_code >= KEY_CLEAR_LO)
                     state <= CLEAR;
                  else
                     state <= OPERATOR;
               end
            end
            DIGIT:
            begin
               if (arg < DATA_W'(ARG_LIMIT)) // extra digits ignored
                  arg <= DATA_W'(arg * DATA_W'(10) + DATA_W'(key_code));
               state <= SHOW_ARG;
            end
            OPERATOR:
            begin
               case (key_code)
                  KEY_MINUS: op_next <= OP_MINUS;
                  KEY_MULT:  op_next <= OP_MULTIPLY;
                  KEY_DIV:   op_next <= OP_DIVIDE;
                  default:   op_next <= OP_PLUS;
               endcase
               state <= CALCULATE;
            end
            CALCULATE:
            begin
               op  <= op_next;
               arg <= '0;
               case (op)
                  OP_PLUS:
                  begin
                     result <= result + arg;
                     state  <= SHOW_RESULT;
                  end
                  OP_MINUS:
                  begin
                     result <= result - arg; // wraps modulo 1024
                     state  <= SHOW_RESULT;
                  end
                  OP_MULTIPLY:
                  begin
                     result <= DATA_W'(result * arg);
                     state  <= SHOW_RESULT;
                  end
                  default:
                  begin
                     div_start <= 1'b1;
                     state     <= DIVIDING;
                  end
               endcase
            end
            DIVIDING:
            begin
               if (div_done)
               begin
                  result <= div_quot;
                  state  <= SHOW_RESULT;
               end
            end
            SHOW_ARG:
            begin
               show_value <= arg;
               state      <= READ;
            end
            SHOW_RESULT:
            begin
               show_value <= result;
               state      <= READ;
            end
            default:
               state <= CLEAR;
         endcase
      end
   end

   // divider operands, sampled by the divider with div_start
   always_ff @(posedge clk)
   begin
      if (state == CALCULATE && op == OP_DIVIDE)
      begin
         div_num <= result;
         div_den <= arg;
      end
   end

endmodule

//--- rtl/seq_divider.sv
// sequential restoring divider
// one quotient bit per cycle, zero divisor gives all ones
`timescale 1ns/100ps

module seq_divider (
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        div_start,
   input  logic [calc_pkg::DATA_W-1:0] div_num,
   input  logic [calc_pkg::DATA_W-1:0] div_den,
   output logic [calc_pkg::DATA_W-1:0] div_quot,
   output logic                        div_done
);
   import calc_pkg::*;

   logic                        busy;
   logic [$clog2(DATA_W)-1:0]   cnt;
   logic [DATA_W-1:0]           rem;
   logic [DATA_W-1:0]           quo; // dividend shifts out, quotient shifts in
   logic [DATA_W-1:0]           den;
   logic [DATA_W:0]             shifted;
   logic [DATA_W:0]             diff;
   logic                        q_bit;

   assign shifted = {rem, quo[DATA_W-1]};
   assign q_bit   = shifted >= {1'b0, den};
   assign diff    = q_bit ? shifted - {1'b0, den} : shifted; // restore on borrow

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         busy     <= 1'b0;
         cnt      <= '0;
         div_done <= 1'b0;
      end
      else
      begin
         div_done <= 1'b0;
         if (div_start)
         begin
            busy <= 1'b1;
            cnt  <= '0;
         end
         else if (busy)
         begin
            cnt <= cnt + 1'b1;
            if (cnt == ($clog2(DATA_W))'(DATA_W - 1))
            begin
               busy     <= 1'b0;
               div_done <= 1'b1; // DATA_W+1 cycles after start
            end
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (div_start)
      begin
         rem <= '0;
         quo <= div_num;
         den <= div_den;
      end
      else if (busy)
      begin
         rem <= diff[DATA_W-1:0];
         quo <= {quo[DATA_W-2:0], q_bit};
         if (cnt == ($clog2(DATA_W))'(DATA_W - 1))
            div_quot <= {quo[DATA_W-2:0], q_bit};
      end
   end

endmodule

//--- rtl/display_driver.sv
// seven segment display driver
// binary to BCD, rotates one lit digit per scan tick
`timescale 1ns/100ps

module display_driver (
   input  logic                         clk,
   input  logic                         rst_n,
   input  logic                         scan_tick,
   input  logic [calc_pkg::DATA_W-1:0]  show_value,
   output logic [panel_pkg::DIGITS-1:0] digit_en,
   output logic [panel_pkg::SEG_W-1:0]  seg
);
   import calc_pkg::*;
   import panel_pkg::*;

   logic [4*DIGITS-1:0]         bcd;
   logic [$clog2(DIGITS)-1:0]   digit_idx;
   logic [$clog2(DIGITS)-1:0]   idx_next;

   function automatic logic [SEG_W-1:0] seg_encode(input logic [3:0] d);
      case (d)
         4'd0:    seg_encode = 7'h3F;
         4'd1:    seg_encode = 7'h06;
         4'd2:    seg_encode = 7'h5B;
         4'd3:    seg_encode = 7'h4F;
         4'd4:    seg_encode = 7'h66;
         4'd5:    seg_encode = 7'h6D;
         4'd6:    seg_encode = 7'h7D;
         4'd7:    seg_encode = 7'h07;
         4'd8:    seg_encode = 7'h7F;
         4'd9:    seg_encode = 7'h6F;
         default: seg_encode = 7'h40; // dash, never hit
      endcase
   endfunction

   // double dabble
   always_comb
   begin
      bcd = '0;
      for (int i = DATA_W - 1; i >= 0; i--)
      begin
         for (int d = 0; d < DIGITS; d++)
         begin
            if (bcd[4*d +: 4] >= 4'd5)
               bcd[4*d +: 4] = bcd[4*d +: 4] + 4'd3;
         end
         bcd = {bcd[4*DIGITS-2:0], show_value[i]};
      end
   end

   always_comb
   begin
      idx_next = digit_idx;
      if (scan_tick)
         idx_next = (digit_idx == ($clog2(DIGITS))'(DIGITS - 1)) ? '0 : digit_idx + 1'b1;
   end

   // seg refreshed every cycle so a new value shows without waiting a tick
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         digit_idx <= '0;
         digit_en  <= DIGITS'(1);
         seg       <= seg_encode(4'd0);
      end
      else
      begin
         digit_idx <= idx_next;
         digit_en  <= DIGITS'(1) << idx_next;
         seg       <= seg_encode(bcd[4*idx_next +: 4]);
      end
   end

endmodule

//--- rtl/calculator_top.sv
// calculator top level
// keypad scanner, control FSM, divider and display on a shared scan timer
`timescale 1ns/100ps

module calculator_top (
   input  logic                           clk,
   input  logic                           rst_n,
   input  logic [panel_pkg::KEYPAD_N-1:0] key_row,
   output logic [panel_pkg::KEYPAD_N-1:0] key_col,
   output logic [panel_pkg::DIGITS-1:0]   digit_en,
   output logic [panel_pkg::SEG_W-1:0]    seg
);
   import calc_pkg::*;
   import panel_pkg::*;

   logic              scan_tick;
   logic              key_valid;
   logic [KEY_W-1:0]  key_code;
   logic              div_start;
   logic              div_done;
   logic [DATA_W-1:0] div_num;
   logic [DATA_W-1:0] div_den;
   logic [DATA_W-1:0] div_quot;
   logic [DATA_W-1:0] show_value;

   scan_timer timer_inst (
      .clk       (clk),
      .rst_n     (rst_n),
      .scan_tick (scan_tick)
   );

   keypad_scanner scanner_inst (
      .clk       (clk),
      .rst_n     (rst_n),
      .scan_tick (scan_tick),
      .key_row   (key_row),
      .key_col   (key_col),
      .key_valid (key_valid),
      .key_code  (key_code)
   );

   calc_control control_inst (
      .clk        (clk),
      .rst_n      (rst_n),
      .key_valid  (key_valid),
      .key_code   (key_code),
      .div_done   (div_done),
      .div_quot   (div_quot),
      .div_start  (div_start),
      .div_num    (div_num),
      .div_den    (div_den),
      .show_value (show_value)
   );

   seq_divider divider_inst (
      .clk       (clk),
      .rst_n     (rst_n),
      .div_start (div_start),
      .div_num   (div_num),
      .div_den   (div_den),
      .div_quot  (div_quot),
      .div_done  (div_done)
   );

   display_driver display_inst (
      .clk        (clk),
      .rst_n      (rst_n),
      .scan_tick  (scan_tick),
      .show_value (show_value),
      .digit_en   (digit_en),
      .seg        (seg)
   );

endmodule

//--- testbench/calculator_checker.sv
// calculator protocol checker
// one-hot scan outputs and handshake pulse shapes
`timescale 1ns/100ps

module calculator_checker (
   input logic                           clk,
   input logic                           rst_n,
   input logic [panel_pkg::KEYPAD_N-1:0] key_col,
   input logic [panel_pkg::DIGITS-1:0]   digit_en,
   input logic                           key_valid,
   input logic                           div_start,
   input logic                           div_done
);
   import calc_pkg::*;

   int fail_count = 0; // number of failed assertions

   col_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot(key_col))
      else
      begin
         $error("key_col is not one-hot");
         fail_count++;
      end

   digit_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot(digit_en))
      else
      begin
         $error("digit_en is not one-hot");
         fail_count++;
      end

   start_pulse: assert property (@(posedge clk) disable iff (!rst_n)
      div_start |=> !div_start)
      else
      begin
         $error("div_start held longer than one cycle");
         fail_count++;
      end

   // divider latency is fixed
   done_latency: assert property (@(posedge clk) disable iff (!rst_n)
      div_start |-> ##(DATA_W + 1) div_done)
      else
      begin
         $error("div_done missing after div_start");
         fail_count++;
      end

   valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
      key_valid |=> !key_valid)
      else
      begin
         $error("key_valid held longer than one cycle");
         fail_count++;
      end

endmodule

bind calculator_top calculator_checker checker_inst (
   .clk       (clk),
   .rst_n     (rst_n),
   .key_col   (key_col),
   .digit_en  (digit_en),
   .key_valid (key_valid),
   .div_start (div_start),
   .div_done  (div_done)
);

//--- testbench/calculator_tb.sv
// calculator testbench
// random keypad sequences checked against a reference calculator model
`timescale 1ns/100ps

module calculator_tb;
   import calc_pkg::*;
   import panel_pkg::*;

   localparam int WAIT_LIMIT = 4 * KEYPAD_N * SCAN_DIV; // cycles per wait
   localparam int VAL_MASK   = (1 << DATA_W) - 1;
   localparam int HOLD       = 6; // sweeps held and sweeps released

   logic                clk;
   logic                rst_n;
   logic [KEYPAD_N-1:0] key_row;
   logic [KEYPAD_N-1:0] key_col;
   logic [DIGITS-1:0]   digit_en;
   logic [SEG_W-1:0]    seg;

   logic             key_down;
   logic [KEY_W-1:0] held_key;
   logic [31:0]      rng_state;
   int               errors;
   int               checks;

   // reference calculator
   int       m_arg;
   int       m_result;
   calc_op_t m_op;

   calculator_top calculator_inst (
      .clk      (clk),
      .rst_n    (rst_n),
      .key_row  (key_row),
      .key_col  (key_col),
      .digit_en (digit_en),
      .seg      (seg)
   );

   initial
   begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // row lines follow the driven column
   always @(posedge clk)
   begin
      #2;
      if (key_down && key_col[held_key[1:0]])
         key_row = KEYPAD_N'(1) << held_key[3:2];
      else
         key_row = '0;
   end

   function automatic logic [31:0] next_rand();
      rng_state = rng_state * 32'd1664525 + 32'd1013904223;
      return rng_state;
   endfunction

   function automatic int pick(input int n);
      logic [31:0] r;
      r = next_rand();
      return int'(r[31:16]) % n; // upper bits spread better
   endfunction

   function automatic int seg_digit(input logic [SEG_W-1:0] s);
      case (s)
         7'h3F:   return 0;
         7'h06:   return 1;
         7'h5B:   return 2;
         7'h4F:   return 3;
         7'h66:   return 4;
         7'h6D:   return 5;
         7'h7D:   return 6;
         7'h07:   return 7;
         7'h7F:   return 8;
         7'h6F:   return 9;
         default: return -1;
      endcase
   endfunction

   // expected display value after key k
   function automatic int model_key(input int k);
      if (k < KEY_PLUS)
      begin
         if (m_arg < ARG_LIMIT)
            m_arg = (m_arg * 10 + k) & VAL_MASK;
         return m_arg;
      end
      if (k >= KEY_CLEAR_LO)
      begin
         m_arg    = 0;
         m_result = 0;
         m_op     = OP_PLUS;
         return 0;
      end
      case (m_op)
         OP_PLUS:     m_result = (m_result + m_arg) & VAL_MASK;
         OP_MINUS:    m_result = (m_result - m_arg) & VAL_MASK;
         OP_MULTIPLY: m_result = (m_result * m_arg) & VAL_MASK;
         default:     m_result = (m_arg == 0) ? VAL_MASK : m_result / m_arg;
      endcase
      case (k)
         KEY_MINUS: m_op = OP_MINUS;
         KEY_MULT:  m_op = OP_MULTIPLY;
         KEY_DIV:   m_op = OP_DIVIDE;
         default:   m_op = OP_PLUS;
      endcase
      m_arg = 0;
      return m_result;
   endfunction

   task automatic report_finish();
      errors += calculator_inst.checker_inst.fail_count; // bound protocol checker
      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0)
         $display("NO ERRORS");
      else
         $display("ERRORS FOUND");
      $finish;
   endtask

   task automatic timeout_abort(input string what);
      $display("Timeout while waiting for %s", what);
      errors++;
      report_finish();
   endtask

   task automatic wait_column(input int c);
      int n;
      n = 0;
      @(negedge clk);
      while (key_col !== (KEYPAD_N'(1) << c))
      begin
         if (n == WAIT_LIMIT)
            timeout_abort("a keypad column");
         @(negedge clk);
         n++;
      end
   endtask

   task automatic wait_sweeps(input int sweeps);
      repeat (sweeps)
      begin
         wait_column(KEYPAD_N - 1);
         wait_column(0);
      end
   endtask

   task automatic press_key(input int k, input int hold);
      @(negedge clk);
      held_key = KEY_W'(k);
      key_down = 1'b1;
      wait_sweeps(hold);
      key_down = 1'b0;
      wait_sweeps(HOLD); // long enough for divide and display update
   endtask

   task automatic read_display(output int value);
      int n;
      int digit;
      int scale;
      value = 0;
      scale = 1;
      for (int d = 0; d < DIGITS; d++)
      begin
         n = 0;
         @(negedge clk);
         while (digit_en !== (DIGITS'(1) << d))
         begin
            if (n == WAIT_LIMIT)
               timeout_abort("a display digit");
            @(negedge clk);
            n++;
         end
         digit = seg_digit(seg);
         assert (digit >= 0)
         else
         begin
            errors++;
            $display("Error seg 0x%02h on digit %0d is not a decimal digit", seg, d);
            digit = 0;
         end
         value += digit * scale;
         scale *= 10;
      end
   endtask

   task automatic expect_display(input int expected);
      int got;
      read_display(got);
      checks++;
      assert (got == expected)
      else
      begin
         errors++;
         $display("Error show_value expected 0x%h actual 0x%h",
                  DATA_W'(expected), DATA_W'(got));
      end
   endtask

   task automatic key_and_check(input int k, input int hold);
      press_key(k, hold);
      expect_display(model_key(k));
   endtask

   initial
   begin
      rst_n     = 1'b0;
      key_row   = '0;
      key_down  = 1'b0;
      held_key  = '0;
      rng_state = 32'h6473_c1f4;
      errors    = 0;
      checks    = 0;
      m_arg     = 0;
      m_result  = 0;
      m_op      = OP_PLUS;
      repeat (3) @(posedge clk);
      #2;
      rst_n = 1'b1;

      expect_display(0);

      // digit strings that may run past the argument cap
      repeat (6)
      begin
         key_and_check(KEY_CLEAR_LO + pick(2), HOLD);
         repeat (1 + pick(5))
            key_and_check(pick(10), HOLD);
      end

      // plus, minus, multiply chains
      repeat (6)
      begin
         key_and_check(KEY_CLEAR_LO + pick(2), HOLD);
         repeat (4)
         begin
            repeat (1 + pick(3))
               key_and_check(pick(10), HOLD);
            key_and_check(KEY_PLUS + pick(3), HOLD);
         end
      end

      // divide chains with about one in three by zero
      repeat (8)
      begin
         key_and_check(KEY_CLEAR_LO + pick(2), HOLD);
         repeat (1 + pick(3))
            key_and_check(pick(10), HOLD);
         key_and_check(KEY_DIV, HOLD);
         if (pick(3) == 0)
            key_and_check(0, HOLD);
         else
         begin
            repeat (1 + pick(2))
               key_and_check(pick(10), HOLD);
         end
         key_and_check(KEY_PLUS, HOLD); // applies the divide
      end

      // clear in the middle of a chain
      repeat (4)
      begin
         repeat (1 + pick(3))
            key_and_check(pick(10), HOLD);
         key_and_check(KEY_PLUS + pick(4), HOLD);
         repeat (1 + pick(2))
            key_and_check(pick(10), HOLD);
         key_and_check(KEY_CLEAR_LO + pick(2), HOLD);
         repeat (1 + pick(2))
            key_and_check(pick(10), HOLD);
         key_and_check(KEY_PLUS, HOLD);
      end

      // long holds still count once
      key_and_check(KEY_CLEAR_LO, HOLD);
      repeat (3)
         key_and_check(1 + pick(9), 4 * HOLD);

      report_finish();
   end

endmodule

//--- list.f
rtl/calc_pkg.sv
rtl/panel_pkg.sv
rtl/scan_timer.sv
rtl/keypad_scanner.sv
rtl/calc_control.sv
rtl/seq_divider.sv
rtl/display_driver.sv
rtl/calculator_top.sv
testbench/calculator_checker.sv
testbench/calculator_tb.sv

//--- run.sh
#!/bin/sh
# build and run the calculator testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module calculator_tb \
   -f list.f -o calculator_sim

./obj_dir/calculator_sim | tee sim.log

if grep -q "ERRORS FOUND" sim.log; then
   echo "simulation failed"
   exit 1
fi
if ! grep -q "NO ERRORS" sim.log; then
   echo "simulation ended without a verdict"
   exit 1
fi
echo "simulation passed"
